//--- design/exec_config_pkg.sv
package exec_config_pkg;

    // Input slots, execution lanes and retire slots per cycle
    localparam int issue_width = 2;

    // Instruction queue entries
    localparam int iq_depth = 8;

    // Reorder buffer entries, one per tag
    localparam int rob_depth = 8;

    // Cycles a multiply holds its lane
    localparam int mul_cycles = 3;

    // Tag width follows ROB depth
    localparam int tag_bits = $clog2(rob_depth);

    // Multiplier bits folded in per iteration
    localparam int mul_chunk_bits = (32 + mul_cycles - 1) / mul_cycles;

endpackage

//--- design/exec_types_pkg.sv
package exec_types_pkg;

    import exec_config_pkg::*;

    // Integer operations handled by a lane
    // Shifts take the low 5 bits of b, MUL keeps the low word
    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        MUL
    } exec_op_e;

    // Lane FSM
    typedef enum logic {
        IDLE,
        MUL_BUSY
    } lane_state_e;

    // Operand and result word
    typedef logic [31:0] word_t;

    // ROB index handed out in program order
    typedef logic [tag_bits-1:0] rob_tag_t;

    // Retire order number, wraps at 256
    typedef logic [7:0] seq_t;

    // Counts of slots, queue entries and ROB entries
    typedef logic [$clog2(issue_width+1)-1:0] slot_count_t;
    typedef logic [$clog2(iq_depth+1)-1:0]    iq_count_t;
    typedef logic [$clog2(iq_depth)-1:0]      iq_ptr_t;
    typedef logic [$clog2(rob_depth+1)-1:0]   rob_count_t;

    // Multiply iteration index
    typedef logic [$clog2(mul_cycles)-1:0] mul_count_t;

endpackage

//--- design/lane_if.sv
interface lane_if
    import exec_types_pkg::*;
();

    // Issue side, one-cycle strobe while busy is low
    logic     issue_valid;
    exec_op_e issue_op;
    word_t    issue_a;
    word_t    issue_b;
    rob_tag_t issue_tag;

    // High while a multiply occupies the lane
    logic     busy;

    // Completion side, one-cycle strobe
    logic     done;
    rob_tag_t done_tag;
    word_t    done_data;

    modport issuer (
        output issue_valid, issue_op, issue_a, issue_b, issue_tag,
        input  busy
    );

    modport lane (
        input  issue_valid, issue_op, issue_a, issue_b, issue_tag,
        output busy, done, done_tag, done_data
    );

    modport retirer (
        input done, done_tag, done_data
    );

endinterface

//--- design/issue_unit.sv
module issue_unit
    import exec_config_pkg::*;
    import exec_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid [issue_width],
    input  exec_op_e    in_op    [issue_width],
    input  word_t       in_a     [issue_width],
    input  word_t       in_b     [issue_width],
    input  rob_count_t  rob_free,
    output logic        in_ready,
    output slot_count_t alloc_count,
    lane_if.issuer      lanes    [issue_width]
);

    // Circular instruction queue
    exec_op_e q_op  [iq_depth];
    word_t    q_a   [iq_depth];
    word_t    q_b   [iq_depth];
    rob_tag_t q_tag [iq_depth];

    iq_ptr_t   head;
    iq_ptr_t   tail;
    iq_count_t count;
    rob_tag_t  next_tag;

    slot_count_t push_n;
    slot_count_t pop_n;

    // Per lane view of dispatch
    logic        lane_busy [issue_width];
    logic        lane_used [issue_width];
    slot_count_t lane_slot [issue_width];

    // Room for a whole input group in both queue and ROB
    assign in_ready = ((iq_count_t'(iq_depth) - count) >= iq_count_t'(issue_width)) &&
                      (rob_free >= rob_count_t'(issue_width));

    // Slots are packed from 0, so a count is enough
    always_comb begin
        push_n = '0;
        for (int i = 0; i < issue_width; i++) begin
            if (in_ready && in_valid[i]) begin
                push_n = push_n + slot_count_t'(1);
            end
        end
    end

    // ROB allocates the same number of tags
    assign alloc_count = push_n;

    // Oldest entries first, each to the lowest free lane
    always_comb begin : dispatch
        logic stop;
        logic found;
        stop  = 1'b0;
        found = 1'b0;
        pop_n = '0;
        for (int l = 0; l < issue_width; l++) begin
            lane_used[l] = 1'b0;
            lane_slot[l] = '0;
        end
        for (int k = 0; k < issue_width; k++) begin
            found = 1'b0;
            if (!stop && (iq_count_t'(k) < count)) begin
                for (int l = 0; l < issue_width; l++) begin
                    if (!found && !lane_busy[l] && !lane_used[l]) begin
                        found        = 1'b1;
                        lane_used[l] = 1'b1;
                        lane_slot[l] = slot_count_t'(k);
                    end
                end
                // No lane left, younger entries wait behind this one
                if (found) begin
                    pop_n = pop_n + slot_count_t'(1);
                end else begin
                    stop = 1'b1;
                end
            end
        end
    end

    // Drive each lane from its queue slot
    for (genvar g = 0; g < issue_width; g++) begin : g_lane
        iq_ptr_t rd_ptr;
        assign rd_ptr               = head + iq_ptr_t'(lane_slot[g]);
        assign lane_busy[g]         = lanes[g].busy;
        assign lanes[g].issue_valid = lane_used[g];
        assign lanes[g].issue_op    = q_op[rd_ptr];
        assign lanes[g].issue_a     = q_a[rd_ptr];
        assign lanes[g].issue_b     = q_b[rd_ptr];
        assign lanes[g].issue_tag   = q_tag[rd_ptr];
    end

    // Pointers, occupancy and tag counter
    always_ff @(posedge clk) begin
        if (rst) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            next_tag <= '0;
        end else begin
            head     <= head + iq_ptr_t'(pop_n);
            tail     <= tail + iq_ptr_t'(push_n);
            count    <= count + iq_count_t'(push_n) - iq_count_t'(pop_n);
            next_tag <= next_tag + rob_tag_t'(push_n);
        end
    end

    // Write accepted slots, tags in program order
    always_ff @(posedge clk) begin
        for (int i = 0; i < issue_width; i++) begin
            if (in_ready && in_valid[i]) begin
                q_op[tail + iq_ptr_t'(i)]  <= in_op[i];
                q_a[tail + iq_ptr_t'(i)]   <= in_a[i];
                q_b[tail + iq_ptr_t'(i)]   <= in_b[i];
                q_tag[tail + iq_ptr_t'(i)] <= next_tag + rob_tag_t'(i);
            end
        end
    end

endmodule

//--- design/alu_lane.sv
module alu_lane
    import exec_config_pkg::*;
    import exec_types_pkg::*;
(
    input logic  clk,
    input logic  rst,
    lane_if.lane port
);

    lane_state_e state;
    mul_count_t  mul_count;
    logic        done_q;

    // Operands held for the ALU and the multiply loop
    exec_op_e op_q;
    word_t    a_q;
    word_t    b_q;
    rob_tag_t tag_q;
    word_t    acc_q;

    logic  take;
    word_t alu_res;

    // One multiplier chunk, shifted into place
    function automatic word_t partial_product(word_t a, word_t b, mul_count_t idx);
        word_t shift;
        word_t chunk;
        shift = word_t'(idx) * word_t'(mul_chunk_bits);
        chunk = (b >> shift) & word_t'((1 << mul_chunk_bits) - 1);
        return (a * chunk) << shift;
    endfunction

    // New operation only from IDLE
    assign take = (state == IDLE) && port.issue_valid;

    // Single-cycle ops from the held operands
    always_comb begin
        case (op_q)
            ADD:     alu_res = a_q + b_q;
            SUB:     alu_res = a_q - b_q;
            AND:     alu_res = a_q & b_q;
            OR:      alu_res = a_q | b_q;
            XOR:     alu_res = a_q ^ b_q;
            SLL:     alu_res = a_q << b_q[4:0];
            SRL:     alu_res = a_q >> b_q[4:0];
            default: alu_res = acc_q;
        endcase
    end

    assign port.busy      = (state == MUL_BUSY);
    assign port.done      = done_q;
    assign port.done_tag  = tag_q;
    assign port.done_data = alu_res;

    // Lane FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            mul_count <= '0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                IDLE: begin
                    if (take) begin
                        if (port.issue_op == MUL) begin
                            // Chunk 0 folds in on the issue edge
                            state     <= MUL_BUSY;
                            mul_count <= mul_count_t'(1);
                        end else begin
                            done_q <= 1'b1;
                        end
                    end
                end
                MUL_BUSY: begin
                    mul_count <= mul_count + mul_count_t'(1);
                    // Last chunk, product complete next cycle
                    if (mul_count == mul_count_t'(mul_cycles - 1)) begin
                        state  <= IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Operand capture and shift-add accumulation
    always_ff @(posedge clk) begin
        if (take) begin
            op_q  <= port.issue_op;
            a_q   <= port.issue_a;
            b_q   <= port.issue_b;
            tag_q <= port.issue_tag;
            acc_q <= partial_product(port.issue_a, port.issue_b, '0);
        end else if (state == MUL_BUSY) begin
            acc_q <= acc_q + partial_product(a_q, b_q, mul_count);
        end
    end

endmodule

//--- design/reorder_buffer.sv
module reorder_buffer
    import exec_config_pkg::*;
    import exec_types_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  slot_count_t alloc_count,
    output rob_count_t  rob_free,
    output logic        retire_valid [issue_width],
    output word_t       retire_data  [issue_width],
    output seq_t        retire_seq   [issue_width],
    lane_if.retirer     lanes        [issue_width]
);

    // Per tag completion flag and result
    logic  ready  [rob_depth];
    word_t result [rob_depth];

    rob_tag_t   alloc_ptr;
    rob_tag_t   head;
    rob_count_t count;
    seq_t       next_seq;

    slot_count_t retire_n;

    // Completion strobes gathered from the lanes
    logic     lane_done [issue_width];
    rob_tag_t lane_tag  [issue_width];
    word_t    lane_data [issue_width];

    for (genvar g = 0; g < issue_width; g++) begin : g_lane
        assign lane_done[g] = lanes[g].done;
        assign lane_tag[g]  = lanes[g].done_tag;
        assign lane_data[g] = lanes[g].done_data;
    end

    assign rob_free = rob_count_t'(rob_depth) - count;

    // Leading run of ready entries from the head
    always_comb begin : retire
        logic stop;
        rob_tag_t idx;
        stop     = 1'b0;
        idx      = '0;
        retire_n = '0;
        for (int i = 0; i < issue_width; i++) begin
            idx             = head + rob_tag_t'(i);
            retire_valid[i] = 1'b0;
            retire_data[i]  = result[idx];
            retire_seq[i]   = next_seq + seq_t'(i);
            if (!stop && (rob_count_t'(i) < count) && ready[idx]) begin
                retire_valid[i] = 1'b1;
                retire_n        = retire_n + slot_count_t'(1);
            end else begin
                // First gap ends the run, keeps retirement in order
                stop = 1'b1;
            end
        end
    end

    // Flags, pointers and order counter
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int t = 0; t < rob_depth; t++) begin
                ready[t] <= 1'b0;
            end
            alloc_ptr <= '0;
            head      <= '0;
            count     <= '0;
            next_seq  <= '0;
        end else begin
            // Freshly allocated tags start not ready
            for (int i = 0; i < issue_width; i++) begin
                if (slot_count_t'(i) < alloc_count) begin
                    ready[alloc_ptr + rob_tag_t'(i)] <= 1'b0;
                end
            end
            // Lane completions mark their tag
            for (int l = 0; l < issue_width; l++) begin
                if (lane_done[l]) begin
                    ready[lane_tag[l]] <= 1'b1;
                end
            end
            alloc_ptr <= alloc_ptr + rob_tag_t'(alloc_count);
            head      <= head + rob_tag_t'(retire_n);
            count     <= count + rob_count_t'(alloc_count) - rob_count_t'(retire_n);
            next_seq  <= next_seq + seq_t'(retire_n);
        end
    end

    // Result capture by tag
    always_ff @(posedge clk) begin
        for (int l = 0; l < issue_width; l++) begin
            if (lane_done[l]) begin
                result[lane_tag[l]] <= lane_data[l];
            end
        end
    end

endmodule

//--- design/exec_cluster.sv
module exec_cluster
    import exec_config_pkg::*;
    import exec_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid     [issue_width],
    input  exec_op_e in_op        [issue_width],
    input  word_t    in_a         [issue_width],
    input  word_t    in_b         [issue_width],
    output logic     in_ready,
    output logic     retire_valid [issue_width],
    output word_t    retire_data  [issue_width],
    output seq_t     retire_seq   [issue_width]
);

    // Tag allocation handshake between issue and ROB
    slot_count_t alloc_count;
    rob_count_t  rob_free;

    // One bundle per lane
    lane_if lanes [issue_width] ();

    // Queue, tags and in-order dispatch
    issue_unit u_issue_unit (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_op       (in_op),
        .in_a        (in_a),
        .in_b        (in_b),
        .rob_free    (rob_free),
        .in_ready    (in_ready),
        .alloc_count (alloc_count),
        .lanes       (lanes)
    );

    // Identical execution lanes
    for (genvar g = 0; g < issue_width; g++) begin : g_lane
        alu_lane u_alu_lane (
            .clk  (clk),
            .rst  (rst),
            .port (lanes[g])
        );
    end

    // In-order retirement
    reorder_buffer u_reorder_buffer (
        .clk          (clk),
        .rst          (rst),
        .alloc_count  (alloc_count),
        .rob_free     (rob_free),
        .retire_valid (retire_valid),
        .retire_data  (retire_data),
        .retire_seq   (retire_seq),
        .lanes        (lanes)
    );

endmodule

//--- verification/exec_ref_model.svh
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// Expected result of one integer operation
// Shift amount is the low 5 bits of b
function automatic word_t ref_result(exec_op_e op, word_t a, word_t b);
    logic [63:0] product;
    word_t       r;
    // Full 64-bit product, low word kept
    product = {32'b0, a} * {32'b0, b};
    case (op)
        ADD:     r = a + b;
        SUB:     r = a - b;
        AND:     r = a & b;
        OR:      r = a | b;
        XOR:     r = a ^ b;
        SLL:     r = a << b[4:0];
        SRL:     r = a >> b[4:0];
        MUL:     r = product[31:0];
        default: r = '0;
    endcase
    return r;
endfunction

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

`endif

//--- verification/tb_exec_cluster.sv
module tb_exec_cluster
    import exec_config_pkg::*;
    import exec_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    `include "exec_ref_model.svh"

    localparam int clk_period   = 20;
    localparam int rand_groups  = 120;
    localparam int burst_groups = 24;
    localparam int wrap_groups  = 150;
    localparam int pre_groups   = 10;
    localparam int post_groups  = 20;

    // Upper bound on operations, two per group
    localparam int total_ops = 8 + 2 + 2 * (rand_groups + burst_groups + wrap_groups
                                            + pre_groups + post_groups);
    localparam int watchdog_ns = total_ops * (mul_cycles + 4) * clk_period + 2000;

    logic     clk;
    logic     rst;
    logic     in_valid     [issue_width];
    exec_op_e in_op        [issue_width];
    word_t    in_a         [issue_width];
    word_t    in_b         [issue_width];
    logic     in_ready;
    logic     retire_valid [issue_width];
    word_t    retire_data  [issue_width];
    seq_t     retire_seq   [issue_width];

    // Expected results in program order
    word_t       exp_q [$];
    seq_t        exp_seq;
    logic [31:0] lfsr_state;
    string       test_name;
    int          pair_count;
    int          wrap_count;
    logic        stall_seen;

    exec_cluster u_exec_cluster (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_a         (in_a),
        .in_b         (in_b),
        .in_ready     (in_ready),
        .retire_valid (retire_valid),
        .retire_data  (retire_data),
        .retire_seq   (retire_seq)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH test=%s %s expected=0x%08h actual=0x%08h",
                     test_name, what, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    // One LFSR step per bit taken, MSB first
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits       = {bits[30:0], lfsr_state[31]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return bits;
    endfunction

    // Drive a group, hold it until in_ready, then log its results
    task automatic send_group(input int n, input exec_op_e op0, input word_t a0,
                              input word_t b0, input exec_op_e op1, input word_t a1,
                              input word_t b1);
        @(posedge clk);
        in_valid[0] <= 1'b1;
        in_op[0]    <= op0;
        in_a[0]     <= a0;
        in_b[0]     <= b0;
        in_valid[1] <= (n == 2);
        in_op[1]    <= op1;
        in_a[1]     <= a1;
        in_b[1]     <= b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        // Accepted on the coming rising edge
        exp_q.push_back(ref_result(op0, a0, b0));
        if (n == 2) begin
            exp_q.push_back(ref_result(op1, a1, b1));
        end
    endtask

    task automatic random_group(input logic mul_heavy);
        exec_op_e op [2];
        word_t    a  [2];
        word_t    b  [2];
        int       n;
        n = take_bits(1) ? 2 : 1;
        for (int s = 0; s < 2; s++) begin
            // Three in four are MUL in a heavy burst
            if (mul_heavy && take_bits(2) != 0) begin
                op[s] = MUL;
            end else begin
                op[s] = exec_op_e'(3'(take_bits(3)));
            end
            a[s] = take_bits(32);
            b[s] = take_bits(32);
        end
        send_group(n, op[0], a[0], b[0], op[1], a[1], b[1]);
    endtask

    task automatic stop_inputs();
        @(posedge clk);
        in_valid[0] <= 1'b0;
        in_valid[1] <= 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
        // Idle window, stray retires get caught here
        repeat (3) @(negedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst         <= 1'b1;
        in_valid[0] <= 1'b0;
        in_valid[1] <= 1'b0;
        repeat (4) @(posedge clk);
        // In-flight work is dropped by reset
        exp_q.delete();
        exp_seq = '0;
        rst <= 1'b0;
    endtask

    // Retire monitor, outputs sampled mid-cycle
    always @(negedge clk) begin : compare
        word_t expected;
        if (!rst) begin
            if (in_valid[0] && !in_ready) begin
                stall_seen = 1'b1;
            end
            if (retire_valid[1] && !retire_valid[0]) begin
                fail_run("Retire slot 1 was valid while slot 0 was not");
            end else begin
                if (retire_valid[0] && retire_valid[1]) begin
                    pair_count++;
                end
                // Slot 0 holds the oldest result
                for (int i = 0; i < issue_width; i++) begin
                    if (retire_valid[i]) begin
                        if (exp_q.size() == 0) begin
                            fail_run("A result retired with no operation outstanding");
                        end else begin
                            expected = exp_q.pop_front();
                            check_value("retire_data", expected, retire_data[i]);
                            check_value("retire_seq", 32'(exp_seq), 32'(retire_seq[i]));
                            exp_seq = exp_seq + seq_t'(1);
                            if (exp_seq == '0) begin
                                wrap_count++;
                            end
                        end
                    end
                end
            end
        end
    end

    initial begin
        #(watchdog_ns);
        fail_run("Watchdog expired because retirement stalled before all results arrived");
    end

    initial begin
        rst        = 1'b1;
        exp_seq    = '0;
        lfsr_state = 32'd21;
        pair_count = 0;
        wrap_count = 0;
        stall_seen = 1'b0;
        test_name  = "reset";
        for (int i = 0; i < issue_width; i++) begin
            in_valid[i] = 1'b0;
            in_op[i]    = ADD;
            in_a[i]     = '0;
            in_b[i]     = '0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // Every op alone in slot 0, shift amount 19
        test_name = "single_ops";
        for (int k = 0; k < 8; k++) begin
            send_group(1, exec_op_e'(3'(k)), 32'h8765_4321, 32'h0000_0f13,
                       ADD, '0, '0);
        end
        stop_inputs();
        wait_drain();

        test_name = "random_stream";
        for (int g = 0; g < rand_groups; g++) begin
            random_group(1'b0);
        end
        stop_inputs();
        wait_drain();

        // ADD done first, held until MUL retires beside it
        test_name  = "mul_then_add";
        pair_count = 0;
        send_group(2, MUL, 32'h0001_2345, 32'h0000_0321, ADD, 32'h10, 32'h20);
        stop_inputs();
        wait_drain();
        check_value("paired retire cycles", 32'd1, pair_count);

        test_name  = "mul_burst";
        stall_seen = 1'b0;
        for (int g = 0; g < burst_groups; g++) begin
            random_group(1'b1);
        end
        stop_inputs();
        wait_drain();
        check_value("in_ready dropped", 32'd1, 32'(stall_seen));

        test_name = "seq_wrap";
        for (int g = 0; g < wrap_groups; g++) begin
            random_group(1'b0);
        end
        stop_inputs();
        wait_drain();
        check_value("seq wrapped", 32'd1, 32'(wrap_count > 0));

        // Reset with work still in flight
        test_name = "mid_reset";
        for (int g = 0; g < pre_groups; g++) begin
            random_group(1'b0);
        end
        apply_reset();
        repeat (3) begin
            @(negedge clk);
            check_value("retire_valid[0] after reset", 32'd0, 32'(retire_valid[0]));
            check_value("retire_valid[1] after reset", 32'd0, 32'(retire_valid[1]));
            check_value("in_ready after reset", 32'd1, 32'(in_ready));
        end

        test_name = "after_reset";
        for (int g = 0; g < post_groups; g++) begin
            random_group(1'b0);
        end
        stop_inputs();
        wait_drain();

        if (exp_q.size() == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            fail_run("Results were still outstanding at the end of the run");
        end
    end

endmodule

//--- flist.f
+incdir+verification
design/exec_config_pkg.sv
design/exec_types_pkg.sv
design/lane_if.sv
design/issue_unit.sv
design/alu_lane.sv
design/reorder_buffer.sv
design/exec_cluster.sv
verification/tb_exec_cluster.sv
